//--- list.f
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/icache.sv
verilog/dcache.sv
verilog/mem_port_arbiter.sv
verilog/cache_top.sv
tests/tb_mem_model.sv
tests/tb_cache_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

    localparam int N_OPS    = 400;
    localparam int WAIT_MAX = 64;
    localparam int SEED     = 32'hcb674e7b;
    localparam logic [cache_pkg::TAG_W-1:0] ITAG_BASE = 11'h010;
    localparam logic [cache_pkg::TAG_W-1:0] DTAG_BASE = 11'h400; // line_addr bit 13 set.

    logic              Clk;
    logic              arst_n;
    logic              ird;
    logic [15:0]       iaddr;
    logic [15:0]       irdata;
    logic              istall;
    logic              drd;
    logic              dwr;
    logic [15:0]       daddr;
    logic [15:0]       dwdata;
    logic [15:0]       drdata;
    logic              dstall;
    mem_pkg::mem_req_t mem_req;
    logic              mem_busy;
    mem_pkg::line_t    mem_rline;

    int   seed;
    int   n_checks;
    int   n_errors;
    logic timed_out;

    logic [15:0]                 shadow [65536];
    logic [cache_pkg::TAG_W-1:0] itag [8];
    logic [cache_pkg::TAG_W-1:0] dtag [8];
    logic [7:0]                  ivalid;
    logic [7:0]                  dvalid;
    logic [7:0]                  ddirty;
    logic [13:0]                 wb_q [$];
    logic [13:0]                 xfer_q [$];

    cache_top i_dut (
        .Clk         (Clk),
        .i_arst_n    (arst_n),
        .i_ird       (ird),
        .i_iaddr     (iaddr),
        .o_irdata    (irdata),
        .o_istall    (istall),
        .i_drd       (drd),
        .i_dwr       (dwr),
        .i_daddr     (daddr),
        .i_dwdata    (dwdata),
        .o_drdata    (drdata),
        .o_dstall    (dstall),
        .o_mem_req   (mem_req),
        .i_mem_busy  (mem_busy),
        .i_mem_rline (mem_rline)
    );

    tb_mem_model #(.SEED(SEED)) i_mem (
        .Clk      (Clk),
        .i_arst_n (arst_n),
        .i_req    (mem_req),
        .o_busy   (mem_busy),
        .o_rline  (mem_rline)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    function automatic logic [15:0] pat_word(input logic [15:0] a);
        logic [15:0] p;
        p = a * 16'h9e37;
        return p ^ 16'h3c5a;
    endfunction

    // four tags over all indices make lines conflict.
    function automatic logic [15:0] rand_addr(input logic [cache_pkg::TAG_W-1:0] base);
        cache_pkg::addr_fields_t f;
        logic [31:0]             r;
        r        = $random(seed);
        f.tag    = base + {9'd0, r[1:0]};
        f.index  = r[4:2];
        f.offset = r[6:5];
        return f;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic flag_timeout(input string what);
        n_errors++;
        timed_out = 1'b1;
        $display("%s stall did not fall within %0d cycles", what, WAIT_MAX);
    endtask

    task automatic pause_side(input logic data_side);
        @(posedge Clk);
        if (data_side) begin
            drd <= 1'b0;
            dwr <= 1'b0;
        end else begin
            ird <= 1'b0;
        end
    endtask

    task automatic inst_access(input logic [15:0] a);
        cache_pkg::addr_fields_t f;
        logic                    exp_miss;
        int                      cycles;
        f        = a;
        exp_miss = !(ivalid[f.index] && itag[f.index] == f.tag);
        @(posedge Clk);
        ird   <= 1'b1;
        iaddr <= a;
        @(negedge Clk);
        check("o_istall", istall, exp_miss);
        cycles = 0;
        while (istall === 1'b1 && cycles < WAIT_MAX) begin
            @(negedge Clk);
            cycles++;
        end
        if (istall !== 1'b0) begin
            flag_timeout("instruction");
        end else begin
            check("o_irdata", irdata, pat_word(a));
            itag[f.index]   = f.tag;
            ivalid[f.index] = 1'b1;
        end
    endtask

    task automatic data_access(input logic is_wr, input logic [15:0] a, input logic [15:0] wd);
        cache_pkg::addr_fields_t f;
        logic                    exp_miss;
        logic                    exp_wb;
        logic [13:0]             victim;
        int                      cycles;
        f        = a;
        exp_miss = !(dvalid[f.index] && dtag[f.index] == f.tag);
        exp_wb   = exp_miss && dvalid[f.index] && ddirty[f.index];
        victim   = {dtag[f.index], f.index};
        @(posedge Clk);
        drd    <= !is_wr;
        dwr    <= is_wr;
        daddr  <= a;
        dwdata <= wd;
        @(negedge Clk);
        check("o_dstall", dstall, exp_miss);
        cycles = 0;
        while (dstall === 1'b1 && cycles < WAIT_MAX) begin
            @(negedge Clk);
            cycles++;
        end
        if (dstall !== 1'b0) begin
            flag_timeout("data");
        end else begin
            if (exp_wb && wb_q.size() == 0) begin
                n_errors++;
                $display("no writeback seen for dirty victim line 0x%h", victim);
            end else if (exp_wb) begin
                check("o_mem_req.line_addr", wb_q.pop_front(), victim);
            end
            if (wb_q.size() != 0) begin
                n_errors++;
                $display("a writeback appeared without a dirty eviction");
                wb_q.delete();
            end
            if (is_wr) shadow[a] = wd; // lands at the next edge.
            else check("o_drdata", drdata, shadow[a]);
            if (exp_miss) begin
                dtag[f.index]   = f.tag;
                dvalid[f.index] = 1'b1;
                ddirty[f.index] = 1'b0;
            end
            if (is_wr) ddirty[f.index] = 1'b1;
        end
    endtask

    // completed port transfers; writebacks must carry the shadow line.
    always @(negedge Clk) begin
        if (arst_n && mem_req.valid && !mem_busy) begin
            xfer_q.push_back(mem_req.line_addr);
            if (mem_req.op == mem_pkg::MEM_WRITE) begin
                wb_q.push_back(mem_req.line_addr);
                for (int w = 0; w < 4; w++) begin
                    check("o_mem_req.wline", mem_req.wline[63-16*w -: 16],
                          shadow[{mem_req.line_addr, w[1:0]}]);
                end
            end
        end
    end

    initial begin
        seed      = SEED;
        n_checks  = 0;
        n_errors  = 0;
        timed_out = 1'b0;
        arst_n    = 1'b0;
        ird       = 1'b0;
        iaddr     = '0;
        drd       = 1'b0;
        dwr       = 1'b0;
        daddr     = '0;
        dwdata    = '0;
        ivalid    = '0;
        dvalid    = '0;
        ddirty    = '0;
        for (int a = 0; a < 65536; a++) shadow[a] = pat_word(a[15:0]);
        repeat (5) @(posedge Clk);
        arst_n <= 1'b1;
        @(negedge Clk);
        check("o_istall", istall, 1'b0);
        check("o_dstall", dstall, 1'b0);
        check("o_mem_req.valid", mem_req.valid, 1'b0);

        // both caches miss in the same cycle.
        xfer_q.delete();
        fork
            inst_access(rand_addr(ITAG_BASE));
            data_access(1'b0, rand_addr(DTAG_BASE), 16'h0000);
        join
        if (xfer_q.size() == 0) begin
            n_errors++;
            $display("no memory transfer seen for the two first misses");
        end else begin
            check("o_mem_req.line_addr[13]", xfer_q[0][13], 1'b1);
        end

        fork
            begin : inst_stream
                for (int k = 0; k < N_OPS && !timed_out; k++) begin
                    if ($unsigned($random(seed)) % 4 == 0) pause_side(1'b0);
                    else inst_access(rand_addr(ITAG_BASE));
                end
            end
            begin : data_stream
                logic [31:0] r;
                for (int k = 0; k < N_OPS && !timed_out; k++) begin
                    r = $random(seed);
                    if (r[2:0] == 3'd0) pause_side(1'b1);
                    else data_access(r[2:0] >= 3'd5, rand_addr(DTAG_BASE), r[31:16]);
                end
            end
        join

        @(posedge Clk);
        ird <= 1'b0;
        drd <= 1'b0;
        dwr <= 1'b0;
        @(negedge Clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int SEED = 1
) (
    input  logic              Clk,
    input  logic              i_arst_n,
    input  mem_pkg::mem_req_t i_req,
    output logic              o_busy,
    output mem_pkg::line_t    o_rline
);

    localparam int DEPTH    = 1 << mem_pkg::LINE_ADDR_W;
    localparam int MAX_BUSY = 5;

    mem_pkg::line_t mem [DEPTH];
    int             seed;
    int             busy_cnt;

    // odd multiplier gives every word address its own value.
    function automatic logic [15:0] pat_word(input logic [15:0] a);
        logic [15:0] p;
        p = a * 16'h9e37;
        return p ^ 16'h3c5a;
    endfunction

    initial begin
        seed = SEED;
        for (int la = 0; la < DEPTH; la++) begin
            for (int w = 0; w < 4; w++) begin
                mem[la][63-16*w -: 16] = pat_word({la[13:0], w[1:0]}); // word 0 on top.
            end
        end
    end

    assign o_rline = mem[i_req.line_addr];
    assign o_busy  = (busy_cnt != 0);

    // fresh busy period for every request.
    always @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_cnt <= 0;
        end else if (i_req.valid) begin
            if (busy_cnt == 0) begin
                busy_cnt <= $unsigned($random(seed)) % (MAX_BUSY + 1);
            end else begin
                busy_cnt <= busy_cnt - 1;
            end
        end
    end

    always @(posedge Clk) begin
        if (i_req.valid && !o_busy && i_req.op == mem_pkg::MEM_WRITE) begin
            mem[i_req.line_addr] <= i_req.wline;
        end
    end

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                         Clk,
    input  logic                         i_arst_n,
    // instruction side.
    input  logic                         i_ird,
    input  logic [cache_pkg::ADDR_W-1:0] i_iaddr,
    output logic [cache_pkg::WORD_W-1:0] o_irdata,
    output logic                         o_istall,
    // data side.
    input  logic                         i_drd,
    input  logic                         i_dwr,
    input  logic [cache_pkg::ADDR_W-1:0] i_daddr,
    input  logic [cache_pkg::WORD_W-1:0] i_dwdata,
    output logic [cache_pkg::WORD_W-1:0] o_drdata,
    output logic                         o_dstall,
    // memory port.
    output mem_pkg::mem_req_t            o_mem_req,
    input  logic                         i_mem_busy,
    input  mem_pkg::line_t               i_mem_rline
);

    mem_pkg::mem_req_t ireq;
    mem_pkg::mem_req_t dreq;
    logic              idone;
    logic              ddone;

    icache u_icache (
        .Clk         (Clk),
        .i_arst_n    (i_arst_n),
        .i_rd        (i_ird),
        .i_addr      (cache_pkg::addr_fields_t'(i_iaddr)),
        .i_mem_done  (idone),
        .i_mem_rline (i_mem_rline),
        .o_rdata     (o_irdata),
        .o_stall     (o_istall),
        .o_mem_req   (ireq)
    );

    dcache u_dcache (
        .Clk         (Clk),
        .i_arst_n    (i_arst_n),
        .i_rd        (i_drd),
        .i_wr        (i_dwr),
        .i_addr      (cache_pkg::addr_fields_t'(i_daddr)),
        .i_wdata     (i_dwdata),
        .i_mem_done  (ddone),
        .i_mem_rline (i_mem_rline), // shared line captured only on own done.
        .o_rdata     (o_drdata),
        .o_stall     (o_dstall),
        .o_mem_req   (dreq)
    );

    mem_port_arbiter u_arbiter (
        .Clk        (Clk),
        .i_arst_n   (i_arst_n),
        .i_ireq     (ireq),
        .i_dreq     (dreq),
        .i_mem_busy (i_mem_busy),
        .o_mem_req  (o_mem_req),
        .o_idone    (idone),
        .o_ddone    (ddone)
    );

endmodule

//--- verilog/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter (
    input  logic              Clk,
    input  logic              i_arst_n,
    input  mem_pkg::mem_req_t i_ireq,
    input  mem_pkg::mem_req_t i_dreq,
    input  logic              i_mem_busy,
    output mem_pkg::mem_req_t o_mem_req,
    output logic              o_idone,
    output logic              o_ddone
);

    typedef enum logic [1:0] {
        GNT_NONE   = 2'd0,
        GNT_ICACHE = 2'd1,
        GNT_DCACHE = 2'd2
    } grant_t;

    grant_t gnt_q;
    grant_t gnt_sel;
    logic   xfer_done;

    // data side wins when the port is free.
    always_comb begin
        gnt_sel = gnt_q;
        if (gnt_q == GNT_NONE) begin
            if (i_dreq.valid) begin
                gnt_sel = GNT_DCACHE;
            end else if (i_ireq.valid) begin
                gnt_sel = GNT_ICACHE;
            end
        end
    end

    always_comb begin
        case (gnt_sel)
            GNT_DCACHE: o_mem_req = i_dreq;
            GNT_ICACHE: o_mem_req = i_ireq;
            default:    o_mem_req = '0;
        endcase
    end

    assign xfer_done = o_mem_req.valid && !i_mem_busy;
    assign o_idone   = xfer_done && (gnt_sel == GNT_ICACHE);
    assign o_ddone   = xfer_done && (gnt_sel == GNT_DCACHE);

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            gnt_q <= GNT_NONE;
        end else if (xfer_done) begin
            gnt_q <= GNT_NONE;
        end else begin
            gnt_q <= gnt_sel; // hold through busy.
        end
    end

    a_grant_held: assert property (
        @(posedge Clk) disable iff (!i_arst_n)
        gnt_q != GNT_NONE |-> o_mem_req.valid && $stable(o_mem_req.line_addr)
    );

endmodule

//--- verilog/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                         Clk,
    input  logic                         i_arst_n,
    input  logic                         i_rd,
    input  logic                         i_wr,
    input  cache_pkg::addr_fields_t      i_addr,
    input  logic [cache_pkg::WORD_W-1:0] i_wdata,
    input  logic                         i_mem_done,
    input  mem_pkg::line_t               i_mem_rline,
    output logic [cache_pkg::WORD_W-1:0] o_rdata,
    output logic                         o_stall,
    output mem_pkg::mem_req_t            o_mem_req
);

    logic [cache_pkg::TAG_W-1:0]     tag_q [cache_pkg::NUM_LINES];
    mem_pkg::line_t                  data_q [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] valid_q;
    logic [cache_pkg::NUM_LINES-1:0] dirty_q;

    cache_pkg::dcache_state_t state_q;
    cache_pkg::dcache_state_t state_d;
    cache_pkg::dcache_state_t req_state;

    logic        hit;
    logic        miss;
    logic        victim_dirty;
    int unsigned word_lsb;

    assign hit          = valid_q[i_addr.index] && (tag_q[i_addr.index] == i_addr.tag);
    assign miss         = (i_rd || i_wr) && !hit;
    assign victim_dirty = valid_q[i_addr.index] && dirty_q[i_addr.index];

    assign word_lsb = (cache_pkg::LINE_WORDS - 1 - i_addr.offset) * cache_pkg::WORD_W;

    assign o_rdata = data_q[i_addr.index][word_lsb +: cache_pkg::WORD_W];
    assign o_stall = miss;

    // a miss in IDLE asks for memory in the strobe cycle.
    always_comb begin
        req_state = state_q;
        if (state_q == cache_pkg::IDLE && miss) begin
            req_state = victim_dirty ? cache_pkg::WRITEBACK : cache_pkg::REFILL;
        end
    end

    always_comb begin
        state_d = req_state;
        if (i_mem_done) begin
            case (req_state)
                cache_pkg::WRITEBACK: state_d = cache_pkg::REFILL;
                default:              state_d = cache_pkg::IDLE;
            endcase
        end
    end

    always_comb begin
        o_mem_req.valid = (req_state != cache_pkg::IDLE);
        if (req_state == cache_pkg::WRITEBACK) begin
            o_mem_req.op        = mem_pkg::MEM_WRITE;
            o_mem_req.line_addr = {tag_q[i_addr.index], i_addr.index}; // victim.
        end else begin
            o_mem_req.op        = mem_pkg::MEM_READ;
            o_mem_req.line_addr = {i_addr.tag, i_addr.index};
        end
        o_mem_req.wline = data_q[i_addr.index];
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= cache_pkg::IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (i_mem_done) begin
                // both writeback and refill leave the line clean.
                dirty_q[i_addr.index] <= 1'b0;
                if (req_state == cache_pkg::REFILL) begin
                    valid_q[i_addr.index] <= 1'b1;
                end
            end else if (i_wr && hit) begin
                dirty_q[i_addr.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (i_mem_done && req_state == cache_pkg::REFILL) begin
            data_q[i_addr.index] <= i_mem_rline;
            tag_q[i_addr.index]  <= i_addr.tag;
        end else if (i_wr && hit) begin
            data_q[i_addr.index][word_lsb +: cache_pkg::WORD_W] <= i_wdata;
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge Clk) disable iff (!i_arst_n)
        !(i_rd && i_wr)
    );

    // dirty stays set for the whole writeback.
    a_wb_dirty: assert property (
        @(posedge Clk) disable iff (!i_arst_n)
        state_q == cache_pkg::WRITEBACK |-> valid_q[i_addr.index] && dirty_q[i_addr.index]
    );

endmodule

//--- verilog/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                         Clk,
    input  logic                         i_arst_n,
    input  logic                         i_rd,
    input  cache_pkg::addr_fields_t      i_addr,
    input  logic                         i_mem_done,
    input  mem_pkg::line_t               i_mem_rline,
    output logic [cache_pkg::WORD_W-1:0] o_rdata,
    output logic                         o_stall,
    output mem_pkg::mem_req_t            o_mem_req
);

    logic [cache_pkg::TAG_W-1:0]     tag_q [cache_pkg::NUM_LINES];
    mem_pkg::line_t                  data_q [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] valid_q;

    logic        hit;
    logic        miss;
    int unsigned word_lsb;

    assign hit  = valid_q[i_addr.index] && (tag_q[i_addr.index] == i_addr.tag);
    assign miss = i_rd && !hit;

    // word 0 sits at the top of the line.
    assign word_lsb = (cache_pkg::LINE_WORDS - 1 - i_addr.offset) * cache_pkg::WORD_W;

    assign o_rdata = data_q[i_addr.index][word_lsb +: cache_pkg::WORD_W];
    assign o_stall = miss;

    always_comb begin
        o_mem_req.valid     = miss;
        o_mem_req.op        = mem_pkg::MEM_READ;
        o_mem_req.line_addr = {i_addr.tag, i_addr.index};
        o_mem_req.wline     = '0; // read only.
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
        end else if (i_mem_done) begin
            valid_q[i_addr.index] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_mem_done) begin
            data_q[i_addr.index] <= i_mem_rline;
            tag_q[i_addr.index]  <= i_addr.tag;
        end
    end

    // a finished refill leaves the line resident, so the request drops.
    a_refill_hits: assert property (
        @(posedge Clk) disable iff (!i_arst_n)
        i_mem_done |=> hit && !o_mem_req.valid
    );

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;

    localparam int LINE_W      = 64; // word 0 in the top bits.
    localparam int LINE_ADDR_W = 14; // tag and index.

    typedef logic [LINE_W-1:0] line_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

    // one line transfer on the shared port.
    typedef struct packed {
        logic                   valid;
        mem_op_t                op;
        logic [LINE_ADDR_W-1:0] line_addr;
        line_t                  wline;
    } mem_req_t;

endpackage

//--- verilog/cache_pkg.sv
package cache_pkg;

    // geometry of both caches.
    localparam int WORD_W     = 16;
    localparam int ADDR_W     = 16;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 8;
    localparam int OFFSET_W   = 2;
    localparam int INDEX_W    = 3;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // word address split, tag in the top bits.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WRITEBACK = 2'd1, // victim line going out.
        REFILL    = 2'd2
    } dcache_state_t;

endpackage
